// ==== logic/rvCorePkg.sv ====
/*
 * Shared types and constants of the RV32 pipelined core.
 * Only word access, the kept ALU operations, BEQ, BNE, JAL and MUL are encoded.
 * MulStages must stay equal to the E-to-W distance (2).
 */
`default_nettype none

package rvCorePkg;

	typedef logic [31:0] wordT;
	typedef logic [31:0] instrT;
	typedef logic [4:0]  regIdxT;

	typedef enum logic [2:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluPassB
	} aluOpT;

	typedef enum logic [1:0] {
		ResAlu, ResMem, ResMul
	} resultSelT;

	// Decoded control, all zero for a bubble
	typedef struct packed {
		aluOpT     aluOp;
		logic      immSrc;
		logic      link;
		logic      memRead;
		logic      memWrite;
		logic      regWrite;
		logic      isMul;
		resultSelT resultSel;
	} ctrlT;

	typedef struct packed {
		logic   valid;
		ctrlT   ctrl;
		wordT   pc;
		wordT   rd1;
		wordT   rd2;
		wordT   imm;
		regIdxT rs1;
		regIdxT rs2;
		regIdxT rd;
	} deStageT;

	typedef struct packed {
		ctrlT   ctrl;
		wordT   aluOut;
		wordT   storeData;
		regIdxT rd;
	} emStageT;

	// Multiplier consumes its low bits first
	typedef struct packed {
		logic   valid;
		regIdxT rd;
		wordT   multiplicand;
		wordT   multiplier;
		wordT   acc;
	} mulStageT;

	// Register write request, also used for the M-stage forward
	typedef struct packed {
		logic   en;
		regIdxT rd;
		wordT   data;
	} wbT;

	// What decode needs from the instruction in E
	typedef struct packed {
		regIdxT rd;
		logic   regWrite;
		logic   memRead;
		logic   isMul;
	} exHazT;

	localparam int MulStages = 2;
	localparam int MulSlice  = 32 / MulStages;

	localparam logic [6:0] OpRType  = 7'b0110011;
	localparam logic [6:0] OpIType  = 7'b0010011;
	localparam logic [6:0] OpLoad   = 7'b0000011;
	localparam logic [6:0] OpStore  = 7'b0100011;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJal    = 7'b1101111;
	localparam logic [6:0] OpLui    = 7'b0110111;

	localparam logic [2:0] Funct3AddSub = 3'b000;
	localparam logic [2:0] Funct3Slt    = 3'b010;
	localparam logic [2:0] Funct3Xor    = 3'b100;
	localparam logic [2:0] Funct3Or     = 3'b110;
	localparam logic [2:0] Funct3And    = 3'b111;
	localparam logic [2:0] Funct3Beq    = 3'b000;
	localparam logic [2:0] Funct3Bne    = 3'b001;
	localparam logic [2:0] Funct3Word   = 3'b010;

	localparam logic [6:0] Funct7Sub = 7'b0100000;
	localparam logic [6:0] Funct7Mul = 7'b0000001;

endpackage

`default_nettype wire

// ==== logic/frontEnd.sv ====
/*
 * Fetch and decode: PC, F/D register, register file, control decode.
 * BEQ, BNE and JAL resolve here; one wrong-path fetch becomes a bubble.
 * Register file is write-first, x0 reads as zero.
 */
`timescale 1ns/10ps
`default_nettype none

module frontEnd import rvCorePkg::*; (
	input  wire           clk,
	input  wire           rstN,
	input  wire instrT    instr,
	output wordT          pc,
	input  wire wbT       wb,
	input  wire wbT       mFwd,
	input  wire exHazT    exHazard,
	input  wire mulStageT mulBusy,
	output deStageT       deOut
);

	logic   fdValid;
	wordT   fdPc;
	instrT  fdInstr;
	wordT   rf [32];
	regIdxT rs1, rs2, rd;
	ctrlT   ctrl;
	wordT   imm, rd1, rd2, cmpA, cmpB, immB, immJ;
	logic   isBranch, isJal, usesRs1, usesRs2;
	logic   stall, redirect;

	function automatic logic readsReg(regIdxT r);
		return (r != '0) && ((usesRs1 && rs1 == r) || (usesRs2 && rs2 == r));
	endfunction

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			fdValid <= 1'b0;
		end else if (redirect) begin
			pc <= fdPc + (isJal ? immJ : immB);
			fdValid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 32'd4;
			fdValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fdPc <= pc;
			fdInstr <= instr;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	assign rs1 = fdInstr[19:15];
	assign rs2 = fdInstr[24:20];
	assign rd  = fdInstr[11:7];
	assign immB = {{19{fdInstr[31]}}, fdInstr[31], fdInstr[7], fdInstr[30:25],
		fdInstr[11:8], 1'b0};
	assign immJ = {{11{fdInstr[31]}}, fdInstr[31], fdInstr[19:12], fdInstr[20],
		fdInstr[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		imm = {{20{fdInstr[31]}}, fdInstr[31:20]};
		isBranch = 1'b0;
		isJal = 1'b0;
		usesRs1 = 1'b0;
		usesRs2 = 1'b0;
		case (fdInstr[6:0])
			OpRType: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				ctrl.regWrite = 1'b1;
				if (fdInstr[31:25] == Funct7Mul) begin
					ctrl.isMul = 1'b1;
					ctrl.resultSel = ResMul;
				end else begin
					case (fdInstr[14:12])
						Funct3AddSub: ctrl.aluOp = (fdInstr[31:25] == Funct7Sub) ? AluSub : AluAdd;
						Funct3Slt:    ctrl.aluOp = AluSlt;
						Funct3Xor:    ctrl.aluOp = AluXor;
						Funct3Or:     ctrl.aluOp = AluOr;
						Funct3And:    ctrl.aluOp = AluAnd;
						default:      ctrl.regWrite = 1'b0;
					endcase
				end
			end
			OpIType: begin
				usesRs1 = 1'b1;
				ctrl.immSrc = 1'b1;
				ctrl.regWrite = (fdInstr[14:12] == Funct3AddSub);
			end
			OpLoad: begin
				usesRs1 = 1'b1;
				ctrl.immSrc = 1'b1;
				ctrl.memRead = (fdInstr[14:12] == Funct3Word);
				ctrl.regWrite = ctrl.memRead;
				ctrl.resultSel = ResMem;
			end
			OpStore: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				ctrl.immSrc = 1'b1;
				ctrl.memWrite = (fdInstr[14:12] == Funct3Word);
				imm = {{20{fdInstr[31]}}, fdInstr[31:25], fdInstr[11:7]};
			end
			OpBranch: begin
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
				isBranch = 1'b1;
				imm = immB;
			end
			OpJal: begin
				// Link value PC+4 is formed by the ALU in E
				isJal = 1'b1;
				ctrl.link = 1'b1;
				ctrl.immSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = 32'd4;
			end
			OpLui: begin
				ctrl.immSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = AluPassB;
				imm = {fdInstr[31:12], 12'b0};
			end
			default: ;
		endcase
		// Writes to x0 are dropped here so nothing downstream forwards them
		if (rd == '0) begin
			ctrl.regWrite = 1'b0;
		end
		if (!fdValid) begin
			ctrl = '0;
		end
	end

	// Register file, written at the end of W
	always_ff @(posedge clk) begin
		if (wb.en) begin
			rf[wb.rd] <= wb.data;
		end
	end

	assign rd1 = (rs1 == '0) ? '0 : (wb.en && wb.rd == rs1) ? wb.data : rf[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (wb.en && wb.rd == rs2) ? wb.data : rf[rs2];

	// Branch operands also see the result sitting in M
	assign cmpA = (mFwd.en && mFwd.rd == rs1) ? mFwd.data : rd1;
	assign cmpB = (mFwd.en && mFwd.rd == rs2) ? mFwd.data : rd2;

	////////////////////////////////////////////////////////////
	// Hazards and redirect
	////////////////////////////////////////////////////////////
	always_comb begin
		stall = 1'b0;
		if (exHazard.memRead && readsReg(exHazard.rd)) begin
			stall = 1'b1;
		end
		// MUL result exists only once it reaches W
		if (exHazard.isMul && readsReg(exHazard.rd)) begin
			stall = 1'b1;
		end
		if (mulBusy.valid && readsReg(mulBusy.rd)) begin
			stall = 1'b1;
		end
		// Branch compare cannot wait for an ALU result still in E
		if (isBranch && exHazard.regWrite && readsReg(exHazard.rd)) begin
			stall = 1'b1;
		end
		stall = stall && fdValid;
	end

	assign redirect = fdValid && !stall && (isJal || (isBranch &&
		((fdInstr[14:12] == Funct3Beq && cmpA == cmpB) ||
		(fdInstr[14:12] == Funct3Bne && cmpA != cmpB))));

	assign deOut = '{valid: fdValid && !stall, ctrl: stall ? '0 : ctrl, pc: fdPc,
		rd1: rd1, rd2: rd2, imm: imm, rs1: rs1, rs2: rs2, rd: rd};

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
/*
 * D/E register, operand forwarding, ALU and E/M register.
 * Forward priority is M first, then W, then the register file value.
 * A MUL result is never forwarded from M; decode stalls on it instead.
 */
`timescale 1ns/10ps
`default_nettype none

module executeStage import rvCorePkg::*; (
	input  wire          clk,
	input  wire          rstN,
	input  wire deStageT deIn,
	input  wire wbT      wb,
	input  wire wordT    memData,
	output emStageT      emOut,
	output mulStageT     mulOut,
	output wbT           mFwd,
	output exHazT        exHazard,
	output logic         memRead,
	output logic         memWrite,
	output wordT         rwAddress,
	output wordT         writeData
);

	deStageT deQ;
	emStageT emQ;
	wordT    fwdA, fwdB, srcA, srcB, aluOut;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			deQ <= '0;
		end else begin
			deQ <= deIn;
		end
	end

	////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////
	// Load data in M comes straight from the async memory
	assign mFwd.en = emQ.ctrl.regWrite && (emQ.ctrl.resultSel != ResMul);
	assign mFwd.rd = emQ.rd;
	assign mFwd.data = (emQ.ctrl.resultSel == ResMem) ? memData : emQ.aluOut;

	assign fwdA = (mFwd.en && mFwd.rd == deQ.rs1) ? mFwd.data :
		(wb.en && wb.rd == deQ.rs1) ? wb.data : deQ.rd1;
	assign fwdB = (mFwd.en && mFwd.rd == deQ.rs2) ? mFwd.data :
		(wb.en && wb.rd == deQ.rs2) ? wb.data : deQ.rd2;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	assign srcA = deQ.ctrl.link ? deQ.pc : fwdA;
	assign srcB = deQ.ctrl.immSrc ? deQ.imm : fwdB;

	always_comb begin
		case (deQ.ctrl.aluOp)
			AluAdd:   aluOut = srcA + srcB;
			AluSub:   aluOut = srcA - srcB;
			AluAnd:   aluOut = srcA & srcB;
			AluOr:    aluOut = srcA | srcB;
			AluXor:   aluOut = srcA ^ srcB;
			AluSlt:   aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
			AluPassB: aluOut = srcB;
			default:  aluOut = '0;
		endcase
	end

	// First multiplier stage starts from an empty accumulator
	assign mulOut.valid = deQ.valid && deQ.ctrl.isMul;
	assign mulOut.rd = deQ.rd;
	assign mulOut.multiplicand = fwdA;
	assign mulOut.multiplier = fwdB;
	assign mulOut.acc = '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			emQ <= '0;
		end else begin
			emQ.ctrl <= deQ.valid ? deQ.ctrl : '0;
			emQ.aluOut <= aluOut;
			emQ.storeData <= fwdB;
			emQ.rd <= deQ.rd;
		end
	end

	assign exHazard.rd = deQ.rd;
	assign exHazard.regWrite = deQ.ctrl.regWrite;
	assign exHazard.memRead = deQ.ctrl.memRead;
	assign exHazard.isMul = deQ.ctrl.isMul;

	// M-stage memory port
	assign emOut = emQ;
	assign memRead = emQ.ctrl.memRead;
	assign memWrite = emQ.ctrl.memWrite;
	assign rwAddress = emQ.aluOut;
	assign writeData = emQ.storeData;

endmodule

`default_nettype wire

// ==== logic/mulStage.sv ====
/*
 * One shift-add stage of the MUL chain, MulSlice multiplier bits per stage.
 * Only the low 32 bits of the product are kept.
 */
`timescale 1ns/10ps
`default_nettype none

module mulStage import rvCorePkg::*; (
	input  wire           clk,
	input  wire           rstN,
	input  wire mulStageT in,
	output mulStageT      out
);

	wordT partial;

	// Add shifted multiplicand for each set bit of this slice
	always_comb begin
		partial = in.acc;
		for (int i = 0; i < MulSlice; i++) begin
			if (in.multiplier[i]) begin
				partial = partial + (in.multiplicand << i);
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			out <= '0;
		end else begin
			out.valid <= in.valid;
			out.rd <= in.rd;
			out.multiplicand <= in.multiplicand << MulSlice;
			out.multiplier <= in.multiplier >> MulSlice;
			out.acc <= partial;
		end
	end

endmodule

`default_nettype wire

// ==== logic/writebackStage.sv ====
/*
 * M/W register and result select toward the register file.
 * The MUL product arrives from the last multiplier stage in the same cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module writebackStage import rvCorePkg::*; (
	input  wire           clk,
	input  wire           rstN,
	input  wire emStageT  emIn,
	input  wire wordT     memData,
	input  wire mulStageT mulIn,
	output wbT            wb
);

	emStageT mwQ;
	wordT    loadQ;
	logic    isMulRes;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mwQ <= '0;
		end else begin
			mwQ <= emIn;
		end
	end

	// Loaded word, only meaningful when the load was in M
	always_ff @(posedge clk) begin
		loadQ <= memData;
	end

	assign isMulRes = (mwQ.ctrl.resultSel == ResMul);

	always_comb begin
		case (mwQ.ctrl.resultSel)
			ResMem:  wb.data = loadQ;
			ResMul:  wb.data = mulIn.acc;
			default: wb.data = mwQ.aluOut;
		endcase
	end

	assign wb.en = mwQ.ctrl.regWrite && (!isMulRes || mulIn.valid);
	assign wb.rd = isMulRes ? mulIn.rd : mwQ.rd;

endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
/*
 * Five-stage RV32 core with a two-stage MUL chain beside M and W.
 * Instruction and data memories must answer combinationally.
 * No stall input; the core never waits on memory.
 */
`timescale 1ns/10ps
`default_nettype none

module rvCore import rvCorePkg::*; (
	input  wire        clk,
	input  wire        rstN,
	input  wire instrT InstrData,
	input  wire wordT  MemData,
	output wordT       PC,
	output logic       MemRead,
	output logic       MemWrite,
	output wordT       RWAddress,
	output wordT       WriteData
);

	deStageT  deBus;
	emStageT  emBus;
	wbT       wbBus;
	wbT       mFwd;
	exHazT    exHaz;
	// Entry n feeds multiplier stage n, last entry is at W
	mulStageT mulChain [MulStages+1];

	frontEnd i_frontEnd (
		.clk      (clk),
		.rstN     (rstN),
		.instr    (InstrData),
		.pc       (PC),
		.wb       (wbBus),
		.mFwd     (mFwd),
		.exHazard (exHaz),
		.mulBusy  (mulChain[1]),
		.deOut    (deBus)
	);

	executeStage i_executeStage (
		.clk        (clk),
		.rstN       (rstN),
		.deIn       (deBus),
		.wb         (wbBus),
		.memData    (MemData),
		.emOut      (emBus),
		.mulOut     (mulChain[0]),
		.mFwd       (mFwd),
		.exHazard   (exHaz),
		.memRead    (MemRead),
		.memWrite   (MemWrite),
		.rwAddress  (RWAddress),
		.writeData  (WriteData)
	);

	for (genvar n = 0; n < MulStages; n++) begin : g_mul
		mulStage i_mulStage (
			.clk  (clk),
			.rstN (rstN),
			.in   (mulChain[n]),
			.out  (mulChain[n+1])
		);
	end

	writebackStage i_writebackStage (
		.clk     (clk),
		.rstN    (rstN),
		.emIn    (emBus),
		.memData (MemData),
		.mulIn   (mulChain[MulStages]),
		.wb      (wbBus)
	);

endmodule

`default_nettype wire

// ==== test/rvCore_assertions.sv ====
/*
 * Concurrent checks on the memory port and PC of rvCore, attached by bind.
 * Assumes no store can reach M within three cycles of reset release.
 */
`timescale 1ns/10ps
`default_nettype none

module rvCore_assertions import rvCorePkg::*; (
	input wire       clk,
	input wire       rstN,
	input wire       MemRead,
	input wire       MemWrite,
	input wire wordT PC
);

	int         failCount = 0;
	logic [1:0] startCycles;

	// Cycles since reset, saturates at 3
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			startCycles <= '0;
		end else if (startCycles != 2'd3) begin
			startCycles <= startCycles + 2'd1;
		end
	end

	strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(MemRead && MemWrite))
	else begin
		failCount++;
		$error("MemRead and MemWrite high in the same cycle");
	end

	// First instruction reaches M on the fourth edge at the earliest
	noEarlyStore: assert property (@(posedge clk) disable iff (!rstN)
		(startCycles != 2'd3) |-> !MemWrite)
	else begin
		failCount++;
		$error("MemWrite high before any store could reach M");
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		PC[1:0] == 2'b00)
	else begin
		failCount++;
		$error("PC is not word aligned");
	end

endmodule

bind rvCore rvCore_assertions i_assertions (
	.clk      (clk),
	.rstN     (rstN),
	.MemRead  (MemRead),
	.MemWrite (MemWrite),
	.PC       (PC)
);

`default_nettype wire

// ==== test/rvCoreTb.sv ====
/*
 * Testbench for rvCore with combinational instruction and data memories.
 * Program starts at address 0 and stores its results from 0x100 upward.
 * Data memory is 4 KB, filled with a pattern of the word index.
 */
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb import rvCorePkg::*; ();

	localparam int    WaitLimit = 200;
	localparam int    ImemWords = 256;
	localparam int    DmemWords = 1024;
	localparam instrT Nop = 32'h00000013;

	typedef struct packed {
		wordT addr;
		wordT data;
	} storeT;

	logic  clk;
	logic  rstN;
	instrT InstrData;
	wordT  MemData;
	wordT  PC;
	logic  MemRead;
	logic  MemWrite;
	wordT  RWAddress;
	wordT  WriteData;

	instrT imem [ImemWords];
	wordT  dmem [DmemWords];
	storeT expStores [$];
	int    progLen;
	wordT  storeAddr;
	wordT  loadAddr;
	wordT  haltPc;
	int    checks;
	int    valueErrors;
	int    otherErrors;
	int    storeCount;
	int    loadCount;

	rvCore i_dut (
		.clk       (clk),
		.rstN      (rstN),
		.InstrData (InstrData),
		.MemData   (MemData),
		.PC        (PC),
		.MemRead   (MemRead),
		.MemWrite  (MemWrite),
		.RWAddress (RWAddress),
		.WriteData (WriteData)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		#2;
		InstrData = imem[PC[9:2]];
		MemData = MemRead ? dmem[RWAddress[11:2]] : '0;
	end

	// Stores land mid-cycle while the strobes are stable
	always @(negedge clk) begin
		if (MemWrite) begin
			dmem[RWAddress[11:2]] <= WriteData;
			storeCount <= storeCount + 1;
		end
	end

	// The program has a single load
	always @(negedge clk) begin
		if (MemRead) begin
			loadCount++;
			checkWord("RWAddress", RWAddress, loadAddr);
		end
	end

	function automatic wordT fillWord(wordT idx);
		return {~idx[15:0], idx[15:0]};
	endfunction

	////////////////////////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////////////////////////
	function automatic instrT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1,
		logic [2:0] f3, regIdxT rd);
		return {f7, rs2, rs1, f3, rd, OpRType};
	endfunction

	function automatic instrT encI(logic [11:0] imm, regIdxT rs1, logic [2:0] f3,
		regIdxT rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instrT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
		return {imm[11:5], rs2, rs1, Funct3Word, imm[4:0], OpStore};
	endfunction

	function automatic instrT encB(logic [12:0] off, regIdxT rs2, regIdxT rs1,
		logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpBranch};
	endfunction

	function automatic instrT encJ(logic [20:0] off, regIdxT rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OpJal};
	endfunction

	function automatic instrT encU(logic [19:0] upper, regIdxT rd);
		return {upper, rd, OpLui};
	endfunction

	task automatic emit(input instrT instr);
		imem[progLen] = instr;
		progLen++;
	endtask

	task automatic pad(input int count);
		repeat (count) emit(Nop);
	endtask

	// SW to the next result slot, plus its expected value
	task automatic storeExpect(input regIdxT rs, input wordT value);
		storeT entry;
		entry.addr = storeAddr;
		entry.data = value;
		emit(encS(storeAddr[11:0], rs, 5'd0));
		expStores.push_back(entry);
		storeAddr += 4;
	endtask

	// LUI then ADDI, upper part rounded for the sign of the low 12 bits
	task automatic loadConst(input regIdxT rd, input wordT value);
		wordT upper;
		upper = (value + 32'h800) >> 12;
		emit(encU(upper[19:0], rd));
		emit(encI(value[11:0], rd, Funct3AddSub, rd, OpIType));
	endtask

	////////////////////////////////////////////////////////////
	// Program and expected stores
	////////////////////////////////////////////////////////////
	task automatic buildProgram();
		wordT        a, b, m1, m2, v11, v12, v13, v14, jalPc;
		logic [11:0] immR, immC, immBr;
		logic [19:0] upR;
		a = $urandom();
		b = $urandom();
		m1 = $urandom();
		m2 = $urandom();
		immR = 12'($urandom());
		immC = 12'($urandom());
		immBr = 12'($urandom());
		upR = 20'($urandom());
		progLen = 0;
		storeAddr = 32'h100;
		loadAddr = 32'h200;

		// ALU operations
		loadConst(5'd1, a);
		loadConst(5'd2, b);
		emit(encR(7'd0, 5'd2, 5'd1, Funct3AddSub, 5'd3));
		storeExpect(5'd3, a + b);
		emit(encR(Funct7Sub, 5'd2, 5'd1, Funct3AddSub, 5'd4));
		storeExpect(5'd4, a - b);
		emit(encR(7'd0, 5'd2, 5'd1, Funct3And, 5'd5));
		storeExpect(5'd5, a & b);
		emit(encR(7'd0, 5'd2, 5'd1, Funct3Or, 5'd6));
		storeExpect(5'd6, a | b);
		emit(encR(7'd0, 5'd2, 5'd1, Funct3Xor, 5'd7));
		storeExpect(5'd7, a ^ b);
		emit(encR(7'd0, 5'd2, 5'd1, Funct3Slt, 5'd8));
		storeExpect(5'd8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		emit(encI(immR, 5'd1, Funct3AddSub, 5'd9, OpIType));
		storeExpect(5'd9, a + {{20{immR[11]}}, immR});
		emit(encU(upR, 5'd10));
		storeExpect(5'd10, {upR, 12'h000});

		// Dependent chain, back to back and then padded
		v11 = {{20{immC[11]}}, immC};
		v12 = v11 + v11;
		v13 = v12 - v11;
		v14 = v13 ^ v12;
		emit(encI(immC, 5'd0, Funct3AddSub, 5'd11, OpIType));
		emit(encR(7'd0, 5'd11, 5'd11, Funct3AddSub, 5'd12));
		emit(encR(Funct7Sub, 5'd11, 5'd12, Funct3AddSub, 5'd13));
		emit(encR(7'd0, 5'd12, 5'd13, Funct3Xor, 5'd14));
		storeExpect(5'd14, v14);
		emit(encI(immC, 5'd0, Funct3AddSub, 5'd15, OpIType));
		pad(3);
		emit(encR(7'd0, 5'd15, 5'd15, Funct3AddSub, 5'd16));
		pad(3);
		emit(encR(Funct7Sub, 5'd15, 5'd16, Funct3AddSub, 5'd17));
		pad(3);
		emit(encR(7'd0, 5'd16, 5'd17, Funct3Xor, 5'd28));
		pad(3);
		storeExpect(5'd28, v14);

		// Load-use
		emit(encI(loadAddr[11:0], 5'd0, Funct3Word, 5'd18, OpLoad));
		emit(encR(7'd0, 5'd1, 5'd18, Funct3AddSub, 5'd19));
		storeExpect(5'd19, fillWord(loadAddr >> 2) + a);

		// Two MULs in flight, the second one used right away
		loadConst(5'd20, m1);
		loadConst(5'd21, m2);
		emit(encR(Funct7Mul, 5'd2, 5'd1, Funct3AddSub, 5'd24));
		emit(encR(Funct7Mul, 5'd21, 5'd20, Funct3AddSub, 5'd22));
		emit(encR(7'd0, 5'd1, 5'd22, Funct3AddSub, 5'd23));
		storeExpect(5'd23, m1 * m2 + a);
		storeExpect(5'd22, m1 * m2);
		storeExpect(5'd24, a * b);

		// Taken BEQ skips a marker, BNE falls through, JAL skips another
		emit(encI(immBr, 5'd0, Funct3AddSub, 5'd25, OpIType));
		emit(encI(immBr, 5'd0, Funct3AddSub, 5'd26, OpIType));
		emit(encB(13'd8, 5'd26, 5'd25, Funct3Beq));
		emit(encS(12'h1F0, 5'd1, 5'd0));
		emit(encB(13'd8, 5'd26, 5'd25, Funct3Bne));
		storeExpect(5'd25, {{20{immBr[11]}}, immBr});
		jalPc = wordT'(progLen * 4);
		emit(encJ(21'd8, 5'd27));
		emit(encS(12'h1F4, 5'd2, 5'd0));
		storeExpect(5'd27, jalPc + 32'd4);
		haltPc = wordT'(progLen * 4);
		emit(encJ(21'd0, 5'd0));
	endtask

	////////////////////////////////////////////////////////////
	// Waits and checks
	////////////////////////////////////////////////////////////
	task automatic waitStore(output logic found);
		found = 1'b0;
		for (int n = 0; n < WaitLimit && !found; n++) begin
			@(negedge clk);
			found = MemWrite;
		end
	endtask

	task automatic waitPc(input wordT target, output logic found);
		found = 1'b0;
		for (int n = 0; n < WaitLimit && !found; n++) begin
			@(negedge clk);
			found = (PC === target);
		end
	endtask

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		checks++;
		if (got !== exp) begin
			$display("error %s got 0x%08h expected 0x%08h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic checkPc(input wordT got, input wordT exp);
		checks++;
		if (got !== exp) begin
			$display("error PC got 0x%08h expected 0x%08h", got, exp);
			valueErrors++;
		end
	endtask

	initial begin
		logic found;
		logic timedOut;
		clk = 1'b0;
		rstN = 1'b0;
		InstrData = Nop;
		MemData = '0;
		checks = 0;
		valueErrors = 0;
		otherErrors = 0;
		storeCount = 0;
		loadCount = 0;
		timedOut = 1'b0;
		void'($urandom(6));
		for (int i = 0; i < ImemWords; i++) begin
			imem[i] = Nop;
		end
		for (int i = 0; i < DmemWords; i++) begin
			dmem[i] = fillWord(i);
		end
		buildProgram();

		repeat (3) @(posedge clk);
		#2 rstN = 1'b1;

		for (int k = 0; k < expStores.size() && !timedOut; k++) begin
			waitStore(found);
			if (!found) begin
				$display("store %0d to 0x%08h did not appear within %0d cycles",
					k, expStores[k].addr, WaitLimit);
				otherErrors++;
				timedOut = 1'b1;
			end else begin
				checkWord("RWAddress", RWAddress, expStores[k].addr);
				checkWord("WriteData", WriteData, expStores[k].data);
			end
		end

		// Halt loop alternates between the JAL and its wrong-path fetch
		if (!timedOut) begin
			waitPc(haltPc, found);
			if (!found) begin
				$display("PC never reached the halt loop at 0x%08h", haltPc);
				otherErrors++;
			end else begin
				@(negedge clk);
				checkPc(PC, haltPc + 32'd4);
				@(negedge clk);
				checkPc(PC, haltPc);
			end
		end

		if (storeCount != expStores.size()) begin
			$display("saw %0d stores but expected %0d", storeCount, expStores.size());
			otherErrors++;
		end
		if (loadCount != 1) begin
			$display("saw %0d loads but expected 1", loadCount);
			otherErrors++;
		end
		if (i_dut.i_assertions.failCount != 0) begin
			$display("%0d assertion failures during the run", i_dut.i_assertions.failCount);
			otherErrors += i_dut.i_assertions.failCount;
		end

		$display("%0d checks, %0d value errors, %0d other errors",
			checks, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/rvCorePkg.sv
logic/frontEnd.sv
logic/executeStage.sv
logic/mulStage.sv
logic/writebackStage.sv
logic/rvCore.sv
test/rvCore_assertions.sv
test/rvCoreTb.sv
